//--- Bender.yml
package:
  name: uart_mem_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ub_pkg.sv
      - uart_rx.sv
      - frame_assembler.sv
      - cmd_sequencer.sv
      - word_serializer.sv
      - uart_tx.sv
      - uart_mem_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_mem_bridge.sv

//--- cmd_sequencer.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module cmd_sequencer (
	input  logic              i_reset,
	input  logic              w_clk_div,
	input  logic              i_frame_valid,
	input  ub_pkg::mem_word_t i_frame,
	input  ub_pkg::mem_word_t i_mem_rddata,
	input  logic              i_mem_rddata_valid,
	input  logic              i_word_done,
	output logic              o_mem_cmd_en,
	output logic              o_mem_cmd_rd,
	output ub_pkg::bank_t     o_mem_bank,
	output ub_pkg::row_t      o_mem_row,
	output ub_pkg::col_t      o_mem_col,
	output ub_pkg::mem_word_t o_mem_wrdata,
	output logic              o_send_word,
	output ub_pkg::mem_word_t o_word,
	output logic              o_send_ack
);
	import ub_pkg::*;

	localparam mem_addr_t lp_step = mem_addr_t'(`UB_ADDR_STEP);

	seq_state_t r_state;
	mem_addr_t r_cur_addr; // write address
	mem_addr_t r_start_addr; // range read bounds
	mem_addr_t r_end_addr;
	mem_addr_t r_rd_addr; // read pointer
	mem_addr_t w_mem_addr;
	logic w_is_clr;
	logic w_is_read;
	logic w_is_setaddr;
	logic w_is_write;

	// frame decode, priority clear > read > set address > write
	assign w_is_clr = (i_frame == {`UB_FRAME_BYTES{`UB_CMD_CLR_BYTE}});
	assign w_is_read = (i_frame[127:64] == {8{`UB_CMD_READ_BYTE}}) &&
		(i_frame[58:32] != i_frame[26:0]); // empty range is a plain write
	assign w_is_setaddr = (i_frame[127:64] == {8{`UB_CMD_SETADDR_BYTE}});
	assign w_is_write = !w_is_clr && !w_is_read && !w_is_setaddr;

	// reads use their own pointer, write address untouched
	assign w_mem_addr = o_mem_cmd_rd ? r_rd_addr : r_cur_addr;
	assign {o_mem_bank, o_mem_row, o_mem_col} = w_mem_addr;

	always_ff @(posedge w_clk_div) begin
		if (i_reset) begin
			r_state <= st_idle;
			r_cur_addr <= '0;
			r_start_addr <= '0;
			r_end_addr <= '0;
			r_rd_addr <= '0;
			o_mem_cmd_en <= 1'b0;
			o_mem_cmd_rd <= 1'b0;
			o_send_word <= 1'b0;
			o_send_ack <= 1'b0;
		end else begin
			o_mem_cmd_en <= 1'b0; // strobes default low
			o_send_word <= 1'b0;
			o_send_ack <= 1'b0;
			case (r_state)
				st_idle: begin
					if (i_frame_valid) begin // frames ignored while busy
						if (w_is_clr) begin
							r_cur_addr <= '0;
							o_send_ack <= 1'b1;
						end else if (w_is_read) begin
							r_start_addr <= i_frame[58:32];
							r_end_addr <= i_frame[26:0];
							r_state <= st_read_setup;
						end else if (w_is_setaddr)
							r_cur_addr <= i_frame[26:0];
						else
							r_state <= st_write_issue;
					end
				end
				st_write_issue: begin
					o_mem_cmd_en <= 1'b1;
					o_mem_cmd_rd <= 1'b0;
					r_state <= st_write_advance;
				end
				st_write_advance: begin
					r_cur_addr <= r_cur_addr + lp_step; // next burst
					r_state <= st_idle;
				end
				st_read_setup: begin
					r_rd_addr <= r_start_addr; // pointer and request land together
					o_mem_cmd_en <= 1'b1;
					o_mem_cmd_rd <= 1'b1;
					r_state <= st_read_wait;
				end
				st_read_req: begin
					o_mem_cmd_en <= 1'b1;
					o_mem_cmd_rd <= 1'b1;
					r_state <= st_read_wait;
				end
				st_read_wait: begin
					if (i_mem_rddata_valid) begin // latency varies
						o_send_word <= 1'b1;
						r_state <= st_read_send;
					end
				end
				st_read_send: begin
					if (i_word_done) begin // all 16 bytes out
						if (r_rd_addr == r_end_addr) begin
							r_rd_addr <= r_start_addr; // back to range start
							o_mem_cmd_rd <= 1'b0;
							r_state <= st_idle;
						end else begin
							r_rd_addr <= r_rd_addr + lp_step;
							r_state <= st_read_req;
						end
					end
				end
				default: r_state <= st_idle;
			endcase
		end
	end

	// burst payloads
	always_ff @(posedge w_clk_div) begin
		if (r_state == st_idle && i_frame_valid && w_is_write)
			o_mem_wrdata <= i_frame;
		if (r_state == st_read_wait && i_mem_rddata_valid)
			o_word <= i_mem_rddata;
	end

endmodule

//--- flist.f
+incdir+.
ub_pkg.sv
uart_rx.sv
frame_assembler.sv
cmd_sequencer.sv
word_serializer.sv
uart_tx.sv
uart_mem_bridge.sv
tb_uart_mem_bridge.sv

//--- frame_assembler.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module frame_assembler (
	input  logic              i_reset,
	input  logic              w_clk_div,
	input  logic              i_rx_valid,
	input  ub_pkg::byte_t     i_rx_byte,
	output logic              o_frame_valid,
	output ub_pkg::mem_word_t o_frame
);
	import ub_pkg::*;

	localparam int lp_idx_w = $clog2(`UB_FRAME_BYTES);
	localparam logic [lp_idx_w-1:0] lp_first = lp_idx_w'(`UB_FRAME_BYTES - 1);

	byte_t r_buf [`UB_FRAME_BYTES]; // entry 15 holds the first byte
	logic [lp_idx_w-1:0] r_idx; // counts down, wraps

	// byte counter and frame strobe
	always_ff @(posedge w_clk_div) begin
		if (i_reset) begin
			r_idx <= lp_first;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0;
			if (i_rx_valid) begin
				r_idx <= r_idx - 1'b1; // wraps to 15 after last byte
				if (r_idx == '0)
					o_frame_valid <= 1'b1; // 16th byte in
			end
		end
	end

	always_ff @(posedge w_clk_div) begin
		if (i_rx_valid)
			r_buf[r_idx] <= i_rx_byte;
	end

	// buffer entry i sits at bits i*8+7:i*8
	always_comb begin
		for (int i = 0; i < `UB_FRAME_BYTES; i++)
			o_frame[i*8 +: 8] = r_buf[i];
	end

endmodule

//--- tb_uart_mem_bridge.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module tb_uart_mem_bridge;
	import ub_pkg::*;

	localparam int lp_bit = `UB_CLKS_PER_BIT;
	localparam int lp_max_cycles = 200000; // tests take about 124k cycles

	logic w_clk_div;
	logic i_reset;
	logic i_uart_rx;
	logic o_uart_tx;
	logic o_mem_cmd_en;
	logic o_mem_cmd_rd;
	bank_t o_mem_bank;
	row_t o_mem_row;
	col_t o_mem_col;
	mem_word_t o_mem_wrdata;
	mem_word_t i_mem_rddata;
	logic i_mem_rddata_valid;

	mem_word_t mem [mem_addr_t]; // behavioral ddr3 contents
	mem_addr_t wr_addr_q [$]; // write log
	mem_word_t wr_data_q [$];
	byte_t rx_q [$]; // bytes seen on o_uart_tx
	logic [31:0] lat_state = 32'd44152; // read latency draws
	logic [31:0] data_state = 32'd44152; // random payload draws
	logic rd_pending = 1'b0;
	int rd_delay;
	mem_addr_t rd_addr;
	int cycle_cnt = 0;
	mem_word_t word_a;
	mem_word_t word_b;
	mem_word_t word_c;
	mem_word_t word_d;

	uart_mem_bridge uart_mem_bridge_i (
		.w_clk_div          (w_clk_div),
		.i_reset            (i_reset),
		.i_uart_rx          (i_uart_rx),
		.o_uart_tx          (o_uart_tx),
		.o_mem_cmd_en       (o_mem_cmd_en),
		.o_mem_cmd_rd       (o_mem_cmd_rd),
		.o_mem_bank         (o_mem_bank),
		.o_mem_row          (o_mem_row),
		.o_mem_col          (o_mem_col),
		.o_mem_wrdata       (o_mem_wrdata),
		.i_mem_rddata       (i_mem_rddata),
		.i_mem_rddata_valid (i_mem_rddata_valid)
	);

	initial w_clk_div = 1'b0;
	always #20 w_clk_div = ~w_clk_div; // 40 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// unwritten locations return an address-derived pattern
	function automatic mem_word_t fill_word(input mem_addr_t a);
		return {4{{5'b0, a} ^ 32'h5a5a_0000}};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] act,
		input logic [127:0] exp);
		if (act !== exp)
			abort_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, act, exp));
	endtask

	always @(posedge w_clk_div) begin
		cycle_cnt++;
		if (cycle_cnt >= lp_max_cycles)
			abort_run("timeout: the tests did not finish within the cycle limit");
	end

	// memory user port model with one outstanding read
	always @(posedge w_clk_div) begin
		i_mem_rddata_valid <= 1'b0;
		if (rd_pending) begin
			if (rd_delay == 0) begin
				i_mem_rddata_valid <= 1'b1;
				i_mem_rddata <= mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
				rd_pending = 1'b0;
			end else
				rd_delay--;
		end
		if (!i_reset && o_mem_cmd_en) begin
			if (o_mem_cmd_rd) begin
				if (rd_pending)
					abort_run("memory model got a read request while one was pending");
				lat_state = xorshift32(lat_state);
				rd_delay = lat_state % 20; // answer after 1 to 20 cycles
				rd_addr = {o_mem_bank, o_mem_row, o_mem_col};
				rd_pending = 1'b1;
			end else begin
				mem[{o_mem_bank, o_mem_row, o_mem_col}] = o_mem_wrdata;
				wr_addr_q.push_back({o_mem_bank, o_mem_row, o_mem_col});
				wr_data_q.push_back(o_mem_wrdata);
			end
		end
	end

	task automatic send_byte(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data lsb first, start
		for (int i = 0; i < 10; i++) begin
			@(posedge w_clk_div);
			i_uart_rx <= bits[i];
			repeat (lp_bit - 1) @(posedge w_clk_div);
		end
	endtask

	task automatic send_frame(input mem_word_t f);
		for (int i = 15; i >= 0; i--)
			send_byte(f[i*8 +: 8]); // msb byte first
	endtask

	// samples each bit at its middle
	task automatic watch_uart_tx();
		byte_t b;
		forever begin
			@(posedge w_clk_div);
			if (o_uart_tx === 1'b0) begin
				repeat (lp_bit / 2) @(posedge w_clk_div);
				if (o_uart_tx !== 1'b0)
					abort_run("uart output start bit did not hold low");
				for (int i = 0; i < 8; i++) begin
					repeat (lp_bit) @(posedge w_clk_div);
					b[i] = o_uart_tx;
				end
				repeat (lp_bit) @(posedge w_clk_div);
				if (o_uart_tx !== 1'b1)
					abort_run("uart output stop bit was not high");
				rx_q.push_back(b);
			end
		end
	endtask

	task automatic wait_write(output mem_addr_t a, output mem_word_t d);
		while (wr_addr_q.size() == 0)
			@(posedge w_clk_div);
		a = wr_addr_q.pop_front();
		d = wr_data_q.pop_front();
	endtask

	task automatic wait_bytes(input int n);
		while (rx_q.size() < n)
			@(posedge w_clk_div);
	endtask

	task automatic expect_write(input mem_addr_t exp_addr, input mem_word_t exp_data);
		mem_addr_t a;
		mem_word_t d;
		wait_write(a, d);
		check_value("o_mem_bank", a[26:24], exp_addr[26:24]);
		check_value("o_mem_row", a[23:10], exp_addr[23:10]);
		check_value("o_mem_col", a[9:0], exp_addr[9:0]);
		check_value("o_mem_wrdata", d, exp_data);
	endtask

	// one word comes back as 16 bytes with bits 127:120 first
	task automatic expect_word_bytes(input mem_word_t w);
		wait_bytes(16);
		for (int i = 15; i >= 0; i--)
			check_value("o_uart_tx byte", rx_q.pop_front(), w[i*8 +: 8]);
	endtask

	function automatic mem_word_t read_frame(input mem_addr_t s, input mem_addr_t e);
		return {{8{`UB_CMD_READ_BYTE}}, 5'b0, s, 5'b0, e};
	endfunction

	task automatic idle_after_reset();
		repeat (100) begin
			@(posedge w_clk_div);
			check_value("o_uart_tx", o_uart_tx, 1'b1);
			check_value("o_mem_cmd_en", o_mem_cmd_en, 1'b0);
		end
	endtask

	task automatic clear_then_first_write();
		send_frame({{8{`UB_CMD_SETADDR_BYTE}}, 64'h240}); // pointer away from 0
		send_frame({`UB_FRAME_BYTES{`UB_CMD_CLR_BYTE}});
		wait_bytes(1);
		check_value("o_uart_tx byte", rx_q.pop_front(), `UB_ACK_BYTE);
		repeat (lp_bit * 20) @(posedge w_clk_div); // room for a stray second byte
		check_value("ack byte count", rx_q.size(), 0);
		check_value("write count after clear", wr_addr_q.size(), 0);
		word_a = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;
		send_frame(word_a);
		expect_write(27'h0, word_a);
	endtask

	task automatic set_address_writes();
		send_frame({{8{`UB_CMD_SETADDR_BYTE}}, 64'h100});
		word_b = 128'hdead_beef_cafe_f00d_1357_9bdf_2468_ace0;
		word_c = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
		send_frame(word_b);
		expect_write(27'h100, word_b);
		send_frame(word_c);
		expect_write(27'h108, word_c);
	endtask

	task automatic range_read_words();
		send_frame(read_frame(27'h100, 27'h108));
		expect_word_bytes(word_b);
		expect_word_bytes(word_c);
		check_value("write count during read", wr_addr_q.size(), 0);
	endtask

	task automatic write_after_read();
		word_a = 128'h8877_6655_4433_2211_0fed_cba9_8765_4321;
		send_frame(word_a);
		expect_write(27'h110, word_a); // write pointer kept past the read
	endtask

	task automatic random_readback();
		for (int i = 0; i < 4; i++) begin
			data_state = xorshift32(data_state);
			word_d[i*32 +: 32] = data_state;
		end
		send_frame(word_d);
		expect_write(27'h118, word_d);
		send_frame(read_frame(27'h110, 27'h118));
		expect_word_bytes(word_a);
		expect_word_bytes(word_d);
	endtask

	initial begin
		i_reset = 1'b1;
		i_uart_rx = 1'b1; // idle line
		i_mem_rddata = '0;
		i_mem_rddata_valid = 1'b0;
		repeat (10) @(posedge w_clk_div);
		i_reset <= 1'b0;
		fork
			watch_uart_tx();
		join_none
		idle_after_reset();
		clear_then_first_write();
		set_address_writes();
		range_read_words();
		write_after_read();
		random_readback();
		repeat (lp_bit * 20) @(posedge w_clk_div);
		check_value("extra uart bytes", rx_q.size(), 0);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- uart_mem_bridge.sv
`timescale 1ns/1ps

module uart_mem_bridge (
	input  logic              w_clk_div,
	input  logic              i_reset,
	input  logic              i_uart_rx,
	output logic              o_uart_tx,
	output logic              o_mem_cmd_en,
	output logic              o_mem_cmd_rd,
	output ub_pkg::bank_t     o_mem_bank,
	output ub_pkg::row_t      o_mem_row,
	output ub_pkg::col_t      o_mem_col,
	output ub_pkg::mem_word_t o_mem_wrdata,
	input  ub_pkg::mem_word_t i_mem_rddata,
	input  logic              i_mem_rddata_valid
);
	import ub_pkg::*;

	logic w_rx_valid; // rx to assembler
	byte_t w_rx_byte;
	logic w_frame_valid; // assembler to sequencer
	mem_word_t w_frame;
	logic w_send_word; // sequencer to serializer
	mem_word_t w_word;
	logic w_send_ack;
	logic w_word_done;
	logic w_tx_start; // serializer to tx
	byte_t w_tx_byte;
	logic w_tx_busy;
	logic w_tx_done;

	uart_rx uart_rx_i (
		.i_reset    (i_reset),
		.w_clk_div  (w_clk_div),
		.i_uart_rx  (i_uart_rx),
		.o_rx_valid (w_rx_valid),
		.o_rx_byte  (w_rx_byte)
	);

	frame_assembler frame_assembler_i (
		.i_reset       (i_reset),
		.w_clk_div     (w_clk_div),
		.i_rx_valid    (w_rx_valid),
		.i_rx_byte     (w_rx_byte),
		.o_frame_valid (w_frame_valid),
		.o_frame       (w_frame)
	);

	cmd_sequencer cmd_sequencer_i (
		.i_reset            (i_reset),
		.w_clk_div          (w_clk_div),
		.i_frame_valid      (w_frame_valid),
		.i_frame            (w_frame),
		.i_mem_rddata       (i_mem_rddata),
		.i_mem_rddata_valid (i_mem_rddata_valid),
		.i_word_done        (w_word_done),
		.o_mem_cmd_en       (o_mem_cmd_en),
		.o_mem_cmd_rd       (o_mem_cmd_rd),
		.o_mem_bank         (o_mem_bank),
		.o_mem_row          (o_mem_row),
		.o_mem_col          (o_mem_col),
		.o_mem_wrdata       (o_mem_wrdata),
		.o_send_word        (w_send_word),
		.o_word             (w_word),
		.o_send_ack         (w_send_ack)
	);

	word_serializer word_serializer_i (
		.i_reset     (i_reset),
		.w_clk_div   (w_clk_div),
		.i_send_word (w_send_word),
		.i_word      (w_word),
		.i_send_ack  (w_send_ack),
		.i_tx_busy   (w_tx_busy),
		.i_tx_done   (w_tx_done),
		.o_tx_start  (w_tx_start),
		.o_tx_byte   (w_tx_byte),
		.o_word_done (w_word_done)
	);

	uart_tx uart_tx_i (
		.i_reset    (i_reset),
		.w_clk_div  (w_clk_div),
		.i_tx_start (w_tx_start),
		.i_tx_byte  (w_tx_byte),
		.o_uart_tx  (o_uart_tx),
		.o_tx_busy  (w_tx_busy),
		.o_tx_done  (w_tx_done)
	);

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module uart_rx #(
	parameter int p_clks_per_bit = `UB_CLKS_PER_BIT
) (
	input  logic          i_reset,
	input  logic          w_clk_div,
	input  logic          i_uart_rx,
	output logic          o_rx_valid,
	output ub_pkg::byte_t o_rx_byte
);
	import ub_pkg::*;

	localparam int lp_cnt_w = $clog2(p_clks_per_bit);
	localparam logic [lp_cnt_w-1:0] lp_full = lp_cnt_w'(p_clks_per_bit - 1);
	localparam logic [lp_cnt_w-1:0] lp_half = lp_cnt_w'(p_clks_per_bit / 2 - 1);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t r_state;
	logic [1:0] r_sync; // two-flop synchronizer
	logic w_line;
	logic [lp_cnt_w-1:0] r_clk_cnt; // clocks within a bit
	logic [2:0] r_bit_cnt; // data bit index
	byte_t r_shift;

	assign w_line = r_sync[1];

	always_ff @(posedge w_clk_div) begin
		if (i_reset) begin
			r_state <= rx_idle;
			r_sync <= 2'b11; // line idles high
			r_clk_cnt <= '0;
			r_bit_cnt <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			r_sync <= {r_sync[0], i_uart_rx};
			o_rx_valid <= 1'b0;
			case (r_state)
				rx_idle: begin
					r_clk_cnt <= '0;
					r_bit_cnt <= '0;
					if (!w_line)
						r_state <= rx_start; // falling edge, start bit
				end
				rx_start: begin
					if (r_clk_cnt == lp_half) begin // middle of start bit
						r_clk_cnt <= '0;
						r_state <= w_line ? rx_idle : rx_data; // glitch goes back
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				rx_data: begin
					if (r_clk_cnt == lp_full) begin // bit center
						r_clk_cnt <= '0;
						r_shift <= {w_line, r_shift[7:1]}; // lsb first
						r_bit_cnt <= r_bit_cnt + 1'b1;
						if (r_bit_cnt == 3'd7)
							r_state <= rx_stop;
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				rx_stop: begin
					if (r_clk_cnt == lp_full) begin // middle of stop bit
						r_clk_cnt <= '0;
						r_state <= rx_idle;
						if (w_line) begin // framing ok
							o_rx_valid <= 1'b1;
							o_rx_byte <= r_shift;
						end
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				default: r_state <= rx_idle;
			endcase
		end
	end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module uart_tx #(
	parameter int p_clks_per_bit = `UB_CLKS_PER_BIT
) (
	input  logic          i_reset,
	input  logic          w_clk_div,
	input  logic          i_tx_start,
	input  ub_pkg::byte_t i_tx_byte,
	output logic          o_uart_tx,
	output logic          o_tx_busy,
	output logic          o_tx_done
);
	import ub_pkg::*;

	localparam int lp_cnt_w = $clog2(p_clks_per_bit);
	localparam logic [lp_cnt_w-1:0] lp_full = lp_cnt_w'(p_clks_per_bit - 1);

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

	tx_state_t r_state;
	logic [lp_cnt_w-1:0] r_clk_cnt; // clocks within a bit
	logic [2:0] r_bit_cnt;
	byte_t r_shift; // data still to go, lsb first

	assign o_tx_busy = (r_state != tx_idle);

	always_ff @(posedge w_clk_div) begin
		if (i_reset) begin
			r_state <= tx_idle;
			r_clk_cnt <= '0;
			r_bit_cnt <= '0;
			o_uart_tx <= 1'b1; // line idles high
			o_tx_done <= 1'b0;
		end else begin
			o_tx_done <= 1'b0;
			case (r_state)
				tx_idle: begin
					o_uart_tx <= 1'b1;
					r_clk_cnt <= '0;
					if (i_tx_start) begin
						r_shift <= i_tx_byte;
						o_uart_tx <= 1'b0; // start bit
						r_state <= tx_start;
					end
				end
				tx_start: begin
					if (r_clk_cnt == lp_full) begin
						r_clk_cnt <= '0;
						r_bit_cnt <= '0;
						o_uart_tx <= r_shift[0]; // first data bit
						r_shift <= r_shift >> 1;
						r_state <= tx_data;
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				tx_data: begin
					if (r_clk_cnt == lp_full) begin
						r_clk_cnt <= '0;
						if (r_bit_cnt == 3'd7) begin
							o_uart_tx <= 1'b1; // stop bit
							r_state <= tx_stop;
						end else begin
							r_bit_cnt <= r_bit_cnt + 1'b1;
							o_uart_tx <= r_shift[0];
							r_shift <= r_shift >> 1;
						end
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				tx_stop: begin
					if (r_clk_cnt == lp_full) begin // end of stop bit
						r_clk_cnt <= '0;
						o_tx_done <= 1'b1;
						r_state <= tx_idle;
					end else
						r_clk_cnt <= r_clk_cnt + 1'b1;
				end
				default: r_state <= tx_idle;
			endcase
		end
	end

endmodule

//--- ub_defs.svh
`ifndef UB_DEFS_SVH
`define UB_DEFS_SVH

// uart timing
// 162.5 MHz divided clock at 3 Mbaud
`define UB_CLKS_PER_BIT 54

// frame layout
// one frame is one 128-bit memory burst
`define UB_FRAME_BYTES 16

// command bytes, replicated over the frame
`define UB_CMD_CLR_BYTE 8'h66 // 'f', clear write address
`define UB_CMD_SETADDR_BYTE 8'h61 // set write address
`define UB_CMD_READ_BYTE 8'h77 // 'w', range read

// reply to a clear command
`define UB_ACK_BYTE 8'h8a

// addressing
// one BL8 burst of x16 covers 8 columns
`define UB_ADDR_STEP 8

`endif

//--- ub_pkg.sv
package ub_pkg;

	// uart payload
	typedef logic [7:0] byte_t;

	// one BL8 burst on a x16 bus, also one full uart frame
	typedef logic [127:0] mem_word_t;

	// linear address split as {bank, row, col}
	typedef logic [26:0] mem_addr_t;

	typedef logic [2:0] bank_t; // 8 banks
	typedef logic [13:0] row_t; // 16k rows
	typedef logic [9:0] col_t; // 1k columns

	// command sequencer states
	typedef enum logic [2:0] {
		st_idle, // waiting for a frame
		st_write_issue, // pulse write request
		st_write_advance, // step write address
		st_read_setup, // load read pointer, first request
		st_read_req, // request next burst
		st_read_wait, // wait for read data
		st_read_send // word out over uart
	} seq_state_t;

endpackage

//--- word_serializer.sv
`timescale 1ns/1ps
`include "ub_defs.svh"

module word_serializer (
	input  logic              i_reset,
	input  logic              w_clk_div,
	input  logic              i_send_word,
	input  ub_pkg::mem_word_t i_word,
	input  logic              i_send_ack,
	input  logic              i_tx_busy,
	input  logic              i_tx_done,
	output logic              o_tx_start,
	output ub_pkg::byte_t     o_tx_byte,
	output logic              o_word_done
);
	import ub_pkg::*;

	localparam int lp_idx_w = $clog2(`UB_FRAME_BYTES);
	localparam logic [lp_idx_w-1:0] lp_first = lp_idx_w'(`UB_FRAME_BYTES - 1);

	mem_word_t r_word;
	logic [lp_idx_w-1:0] r_idx; // msb byte first
	logic r_active; // something left to send
	logic r_ack; // single ack byte mode
	logic r_inflight; // byte handed to tx, waiting for done

	always_ff @(posedge w_clk_div) begin
		if (i_reset) begin
			r_idx <= lp_first;
			r_active <= 1'b0;
			r_ack <= 1'b0;
			r_inflight <= 1'b0;
			o_tx_start <= 1'b0;
			o_word_done <= 1'b0;
		end else begin
			o_tx_start <= 1'b0;
			o_word_done <= 1'b0;
			if (i_send_word) begin
				r_active <= 1'b1;
				r_ack <= 1'b0;
				r_idx <= lp_first;
				r_inflight <= 1'b0;
			end else if (i_send_ack) begin
				r_active <= 1'b1;
				r_ack <= 1'b1;
				r_inflight <= 1'b0;
			end else if (r_active) begin
				if (!r_inflight && !i_tx_busy) begin // tx free, hand over next byte
					o_tx_start <= 1'b1;
					o_tx_byte <= r_ack ? `UB_ACK_BYTE : r_word[r_idx*8 +: 8];
					r_inflight <= 1'b1;
				end else if (r_inflight && i_tx_done) begin
					r_inflight <= 1'b0;
					if (r_ack) begin // ack is one byte, no word done
						r_active <= 1'b0;
						r_ack <= 1'b0;
					end else begin
						r_idx <= r_idx - 1'b1;
						if (r_idx == '0) begin // last byte gone
							r_active <= 1'b0;
							o_word_done <= 1'b1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge w_clk_div) begin
		if (i_send_word)
			r_word <= i_word;
	end

endmodule
